// File: verilog/ifetch_pkg.sv
// Instruction fetch definitions
package ifetch_pkg;
	// Cache geometry
	localparam int ADDR_WIDTH = 32;
	localparam int L1I_WAYS = 2;
	localparam int L1I_SETS = 16;
	localparam int CACHE_LINE_WORDS = 4;
	localparam int CACHE_LINE_BITS = CACHE_LINE_WORDS * 32;
	localparam int CACHE_LINE_OFFSET_WIDTH = $clog2(CACHE_LINE_BITS / 8);
	localparam int THREADS = 4;

	// Address field widths
	localparam int SET_IDX_WIDTH = $clog2(L1I_SETS);
	localparam int TAG_WIDTH = ADDR_WIDTH - SET_IDX_WIDTH - CACHE_LINE_OFFSET_WIDTH;

	typedef logic [31:0] scalar_t;
	typedef logic [TAG_WIDTH-1:0] l1i_tag_t;
	typedef logic [SET_IDX_WIDTH-1:0] l1i_set_idx_t;
	typedef logic [$clog2(L1I_WAYS)-1:0] l1i_way_idx_t;
	typedef logic [$clog2(THREADS)-1:0] thread_idx_t;
	typedef logic [CACHE_LINE_BITS-1:0] cache_line_data_t;

	// Byte address split into cache fields
	typedef struct packed {
		l1i_tag_t tag;
		l1i_set_idx_t set_idx;
		logic [CACHE_LINE_OFFSET_WIDTH-1:0] offset;
	} l1i_addr_t;

	typedef enum logic [2:0] {
		REFILL_IDLE,
		REFILL_ADDR,
		REFILL_DATA,
		REFILL_WRITE,
		REFILL_TAG
	} refill_state_t;

	// AXI read response codes
	typedef enum logic [1:0] {
		RESP_OKAY = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axi_resp_t;
endpackage

// File: verilog/sram_1r1w.sv
// One-read one-write SRAM
`timescale 1ns/1ps

module sram_1r1w #(
	parameter int DATA_WIDTH = 32,
	parameter int SIZE = 64,
	parameter int READ_NEW = 1
)
(
	input logic clk,
	input logic read_en,
	input logic [$clog2(SIZE)-1:0] read_addr,
	output logic [DATA_WIDTH-1:0] read_data,
	input logic write_en,
	input logic [$clog2(SIZE)-1:0] write_addr,
	input logic [DATA_WIDTH-1:0] write_data
);
	logic [DATA_WIDTH-1:0] mem[SIZE];

	always_ff @(posedge clk)
	begin
		if (write_en)
			mem[write_addr] <= write_data;

		// Registered read port
		if (read_en)
		begin
			// Same-address write passes straight through
			if (READ_NEW != 0 && write_en && write_addr == read_addr)
				read_data <= write_data;
			else
				read_data <= mem[read_addr];
		end
	end
endmodule

// File: verilog/ifetch_tag_stage.sv
// Instruction fetch tag stage
`timescale 1ns/1ps

module ifetch_tag_stage
	import ifetch_pkg::*;
(
	input logic clk,
	input logic reset,

	// Accepted fetch request
	input logic fetch_en,
	input l1i_addr_t fetch_pc,
	input thread_idx_t fetch_thread,

	// LRU update from data stage
	input logic ifd_update_lru_en,
	input l1i_way_idx_t ifd_update_lru_way,

	// Tag and valid write from refill
	input logic tag_update_en,
	input l1i_way_idx_t tag_update_way,
	input l1i_set_idx_t tag_update_set,
	input l1i_tag_t tag_update_tag,

	// Registered request to data stage
	output logic ift_request,
	output l1i_addr_t ift_pc,
	output thread_idx_t ift_thread,
	output l1i_tag_t ift_tag[L1I_WAYS],
	output logic [L1I_WAYS-1:0] ift_valid,

	// Victim for refill
	output l1i_way_idx_t lru_way
);
	// Valid bit per way and set
	logic [L1I_WAYS-1:0][L1I_SETS-1:0] valid_bits;
	// One LRU bit per set, names the older way
	logic [L1I_SETS-1:0] lru_bits;

	// Tag arrays, one per way
	for (genvar way = 0; way < L1I_WAYS; way++)
	begin : tag_way_gen
		sram_1r1w #(
			.DATA_WIDTH($bits(l1i_tag_t)),
			.SIZE(L1I_SETS),
			.READ_NEW(1)
		) tag_sram (
			.clk(clk),
			.read_en(fetch_en),
			.read_addr(fetch_pc.set_idx),
			.read_data(ift_tag[way]),
			.write_en(tag_update_en && tag_update_way == l1i_way_idx_t'(way)),
			.write_addr(tag_update_set),
			.write_data(tag_update_tag)
		);
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			valid_bits <= '0;
			lru_bits <= '0;
			ift_valid <= '0;
			ift_request <= 1'b0;
		end
		else
		begin
			ift_request <= fetch_en;
			if (tag_update_en)
				valid_bits[tag_update_way][tag_update_set] <= 1'b1;

			// Valid read, with a same-cycle fill forwarded like the tag
			if (fetch_en)
			begin
				for (int way = 0; way < L1I_WAYS; way++)
				begin
					ift_valid[way] <= valid_bits[way][fetch_pc.set_idx]
						|| (tag_update_en && tag_update_way == l1i_way_idx_t'(way)
						&& tag_update_set == fetch_pc.set_idx);
				end
			end

			// Hit way becomes most recent
			if (ifd_update_lru_en)
				lru_bits[ift_pc.set_idx] <= ~ifd_update_lru_way;
		end
	end

	// Request payload
	always_ff @(posedge clk)
	begin
		if (fetch_en)
		begin
			ift_pc <= fetch_pc;
			ift_thread <= fetch_thread;
		end
	end

	assign lru_way = lru_bits[ift_pc.set_idx];

	// Refill only runs with the front end stalled, so no hit shares its set
	assert property (@(posedge clk) disable iff (reset)
		!(ifd_update_lru_en && tag_update_en && tag_update_set == ift_pc.set_idx));
endmodule

// File: verilog/ifetch_data_stage.sv
// Instruction fetch data stage
`timescale 1ns/1ps

module ifetch_data_stage
	import ifetch_pkg::*;
#(
	parameter int DATA_SRAM_READ_NEW = 1
)
(
	input logic clk,
	input logic reset,

	// From tag stage
	input logic ift_request,
	input l1i_addr_t ift_pc,
	input thread_idx_t ift_thread,
	input l1i_tag_t ift_tag[L1I_WAYS],
	input logic [L1I_WAYS-1:0] ift_valid,

	// Line fill from refill
	input logic data_update_en,
	input l1i_way_idx_t data_update_way,
	input l1i_set_idx_t data_update_set,
	input cache_line_data_t data_update_data,
	input logic tag_update_en,
	input l1i_set_idx_t tag_update_set,
	input l1i_tag_t tag_update_tag,

	// Rollback kill
	input logic rollback_en,
	input thread_idx_t rollback_thread,

	output logic ifd_update_lru_en,
	output l1i_way_idx_t ifd_update_lru_way,
	output logic ifd_cache_miss,
	output scalar_t ifd_cache_miss_pc,
	output thread_idx_t ifd_cache_miss_thread,

	// Fetched instruction
	output logic inst_valid,
	output scalar_t inst,
	output scalar_t inst_pc,
	output thread_idx_t inst_thread,

	output logic perf_hit,
	output logic perf_miss
);
	logic [L1I_WAYS-1:0] way_hit_oh;
	l1i_way_idx_t way_hit_idx;
	logic cache_hit;
	logic near_miss;
	cache_line_data_t fetched_line;
	logic [CACHE_LINE_OFFSET_WIDTH-3:0] lane;
	scalar_t fetched_word;

	// Tag compare per way, then encode
	always_comb
	begin
		way_hit_idx = '0;
		for (int way = 0; way < L1I_WAYS; way++)
		begin
			way_hit_oh[way] = ift_valid[way] && ift_tag[way] == ift_pc.tag;
			if (way_hit_oh[way])
				way_hit_idx = l1i_way_idx_t'(way);
		end
	end

	assign cache_hit = ift_request && |way_hit_oh;

	// Line being tagged right now, so not a new miss
	assign near_miss = ift_request && !(|way_hit_oh) && tag_update_en
		&& tag_update_set == ift_pc.set_idx && tag_update_tag == ift_pc.tag;
	assign ifd_cache_miss = ift_request && !(|way_hit_oh) && !near_miss;
	assign ifd_cache_miss_pc = {ift_pc.tag, ift_pc.set_idx, {CACHE_LINE_OFFSET_WIDTH{1'b0}}};
	assign ifd_cache_miss_thread = ift_thread;

	assign ifd_update_lru_en = cache_hit;
	assign ifd_update_lru_way = way_hit_idx;
	assign perf_hit = cache_hit;
	assign perf_miss = ifd_cache_miss;

	// Line data, addressed by way and set
	sram_1r1w #(
		.DATA_WIDTH(CACHE_LINE_BITS),
		.SIZE(L1I_WAYS * L1I_SETS),
		.READ_NEW(DATA_SRAM_READ_NEW)
	) data_sram (
		.clk(clk),
		.read_en(cache_hit),
		.read_addr({way_hit_idx, ift_pc.set_idx}),
		.read_data(fetched_line),
		.write_en(data_update_en),
		.write_addr({data_update_way, data_update_set}),
		.write_data(data_update_data)
	);

	// Word 0 sits in the top lane of the line
	assign lane = ~inst_pc[CACHE_LINE_OFFSET_WIDTH-1:2];
	assign fetched_word = fetched_line[32 * lane +: 32];
	// Big-endian memory, lowest byte to the top
	assign inst = {fetched_word[7:0], fetched_word[15:8], fetched_word[23:16], fetched_word[31:24]};

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			inst_valid <= 1'b0;
		else
			inst_valid <= cache_hit && !(rollback_en && rollback_thread == ift_thread);
	end

	always_ff @(posedge clk)
	begin
		inst_pc <= ift_pc;
		inst_thread <= ift_thread;
	end

	// Refill never leaves one line in two ways
	assert property (@(posedge clk) disable iff (reset)
		ift_request |-> $onehot0(way_hit_oh));
endmodule

// File: verilog/l2_refill_fsm.sv
// Instruction cache refill engine
`timescale 1ns/1ps

module l2_refill_fsm
	import ifetch_pkg::*;
(
	input logic clk,
	input logic reset,

	// Miss from data stage, victim from tag stage
	input logic ifd_cache_miss,
	input scalar_t ifd_cache_miss_pc,
	input l1i_way_idx_t lru_way,

	output logic busy,

	// AXI4-Lite read master
	output scalar_t m_araddr,
	output logic m_arvalid,
	input logic m_arready,
	input scalar_t m_rdata,
	input logic [1:0] m_rresp,
	input logic m_rvalid,
	output logic m_rready,

	// Data array write
	output logic data_update_en,
	output l1i_way_idx_t data_update_way,
	output l1i_set_idx_t data_update_set,
	output cache_line_data_t data_update_data,

	// Tag and valid write
	output logic tag_update_en,
	output l1i_way_idx_t tag_update_way,
	output l1i_set_idx_t tag_update_set,
	output l1i_tag_t tag_update_tag,

	output logic refill_error
);
	localparam int WORD_IDX_WIDTH = CACHE_LINE_OFFSET_WIDTH - 2;

	refill_state_t state;
	l1i_addr_t miss_addr;
	l1i_way_idx_t victim_way;
	logic [WORD_IDX_WIDTH-1:0] word_idx;
	cache_line_data_t line_buf;
	logic last_word;

	assign last_word = word_idx == WORD_IDX_WIDTH'(CACHE_LINE_WORDS - 1);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= REFILL_IDLE;
			refill_error <= 1'b0;
		end
		else
		begin
			case (state)
				REFILL_IDLE:
					if (ifd_cache_miss)
						state <= REFILL_ADDR;
				REFILL_ADDR:
					if (m_arready)
						state <= REFILL_DATA;
				REFILL_DATA:
					if (m_rvalid)
					begin
						// Sticky error, line still written
						if (axi_resp_t'(m_rresp) != RESP_OKAY)
							refill_error <= 1'b1;
						state <= last_word ? REFILL_WRITE : REFILL_ADDR;
					end
				REFILL_WRITE:
					state <= REFILL_TAG;
				REFILL_TAG:
					state <= REFILL_IDLE;
				default:
					state <= REFILL_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		// Capture line address and victim
		if (state == REFILL_IDLE && ifd_cache_miss)
		begin
			miss_addr <= ifd_cache_miss_pc;
			victim_way <= lru_way;
			word_idx <= '0;
		end
		// Shift each beat in, word 0 ends on top
		else if (state == REFILL_DATA && m_rvalid)
		begin
			line_buf <= {line_buf[CACHE_LINE_BITS-33:0], m_rdata};
			word_idx <= word_idx + 1'b1;
		end
	end

	assign busy = state != REFILL_IDLE;
	assign m_araddr = {miss_addr.tag, miss_addr.set_idx, word_idx, 2'b00};
	assign m_arvalid = state == REFILL_ADDR;
	assign m_rready = state == REFILL_DATA;

	assign data_update_en = state == REFILL_WRITE;
	assign data_update_way = victim_way;
	assign data_update_set = miss_addr.set_idx;
	assign data_update_data = line_buf;

	// Tag goes in one cycle after the data
	assign tag_update_en = state == REFILL_TAG;
	assign tag_update_way = victim_way;
	assign tag_update_set = miss_addr.set_idx;
	assign tag_update_tag = miss_addr.tag;

	// Address held until the slave takes it
	assert property (@(posedge clk) disable iff (reset)
		m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr));
endmodule

// File: verilog/perf_counters.sv
// Cache event counters
`timescale 1ns/1ps

module perf_counters #(
	parameter int COUNTER_WIDTH = 32
)
(
	input logic clk,
	input logic reset,
	input logic perf_hit,
	input logic perf_miss,
	output logic [COUNTER_WIDTH-1:0] hit_count,
	output logic [COUNTER_WIDTH-1:0] miss_count
);
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			hit_count <= '0;
			miss_count <= '0;
		end
		else
		begin
			// Both stick at all ones
			if (perf_hit && hit_count != '1)
				hit_count <= hit_count + 1'b1;
			if (perf_miss && miss_count != '1)
				miss_count <= miss_count + 1'b1;
		end
	end
endmodule

// File: verilog/ifetch_top.sv
// Instruction fetch front end
`timescale 1ns/1ps

module ifetch_top
	import ifetch_pkg::*;
#(
	parameter int COUNTER_WIDTH = 32,
	parameter int DATA_SRAM_READ_NEW = 1
)
(
	input logic clk,
	input logic reset,

	// Fetch request
	input logic fetch_en,
	input scalar_t fetch_pc,
	input thread_idx_t fetch_thread,
	output logic fetch_ready,

	// Result
	output logic inst_valid,
	output scalar_t inst,
	output scalar_t inst_pc,
	output thread_idx_t inst_thread,

	input logic rollback_en,
	input thread_idx_t rollback_thread,

	output logic miss_out,
	output thread_idx_t miss_thread,

	// AXI4-Lite read master
	output scalar_t m_araddr,
	output logic m_arvalid,
	input logic m_arready,
	input scalar_t m_rdata,
	input logic [1:0] m_rresp,
	input logic m_rvalid,
	output logic m_rready,

	output logic refill_error,
	output logic [COUNTER_WIDTH-1:0] hit_count,
	output logic [COUNTER_WIDTH-1:0] miss_count
);
	logic fetch_accept;
	logic refill_busy;

	// Tag stage to data stage
	logic ift_request;
	l1i_addr_t ift_pc;
	thread_idx_t ift_thread;
	l1i_tag_t ift_tag[L1I_WAYS];
	logic [L1I_WAYS-1:0] ift_valid;
	l1i_way_idx_t lru_way;
	logic ifd_update_lru_en;
	l1i_way_idx_t ifd_update_lru_way;
	scalar_t ifd_cache_miss_pc;

	// Refill writes
	logic data_update_en;
	l1i_way_idx_t data_update_way;
	l1i_set_idx_t data_update_set;
	cache_line_data_t data_update_data;
	logic tag_update_en;
	l1i_way_idx_t tag_update_way;
	l1i_set_idx_t tag_update_set;
	l1i_tag_t tag_update_tag;

	logic perf_hit;
	logic perf_miss;

	// Stall new requests for the whole refill
	assign fetch_ready = !refill_busy;
	assign fetch_accept = fetch_en && fetch_ready;

	ifetch_tag_stage tag_stage (
		.clk(clk),
		.reset(reset),
		.fetch_en(fetch_accept),
		.fetch_pc(fetch_pc),
		.fetch_thread(fetch_thread),
		.ifd_update_lru_en(ifd_update_lru_en),
		.ifd_update_lru_way(ifd_update_lru_way),
		.tag_update_en(tag_update_en),
		.tag_update_way(tag_update_way),
		.tag_update_set(tag_update_set),
		.tag_update_tag(tag_update_tag),
		.ift_request(ift_request),
		.ift_pc(ift_pc),
		.ift_thread(ift_thread),
		.ift_tag(ift_tag),
		.ift_valid(ift_valid),
		.lru_way(lru_way)
	);

	ifetch_data_stage #(
		.DATA_SRAM_READ_NEW(DATA_SRAM_READ_NEW)
	) data_stage (
		.clk(clk),
		.reset(reset),
		.ift_request(ift_request),
		.ift_pc(ift_pc),
		.ift_thread(ift_thread),
		.ift_tag(ift_tag),
		.ift_valid(ift_valid),
		.data_update_en(data_update_en),
		.data_update_way(data_update_way),
		.data_update_set(data_update_set),
		.data_update_data(data_update_data),
		.tag_update_en(tag_update_en),
		.tag_update_set(tag_update_set),
		.tag_update_tag(tag_update_tag),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.ifd_update_lru_en(ifd_update_lru_en),
		.ifd_update_lru_way(ifd_update_lru_way),
		.ifd_cache_miss(miss_out),
		.ifd_cache_miss_pc(ifd_cache_miss_pc),
		.ifd_cache_miss_thread(miss_thread),
		.inst_valid(inst_valid),
		.inst(inst),
		.inst_pc(inst_pc),
		.inst_thread(inst_thread),
		.perf_hit(perf_hit),
		.perf_miss(perf_miss)
	);

	l2_refill_fsm refill (
		.clk(clk),
		.reset(reset),
		.ifd_cache_miss(miss_out),
		.ifd_cache_miss_pc(ifd_cache_miss_pc),
		.lru_way(lru_way),
		.busy(refill_busy),
		.m_araddr(m_araddr),
		.m_arvalid(m_arvalid),
		.m_arready(m_arready),
		.m_rdata(m_rdata),
		.m_rresp(m_rresp),
		.m_rvalid(m_rvalid),
		.m_rready(m_rready),
		.data_update_en(data_update_en),
		.data_update_way(data_update_way),
		.data_update_set(data_update_set),
		.data_update_data(data_update_data),
		.tag_update_en(tag_update_en),
		.tag_update_way(tag_update_way),
		.tag_update_set(tag_update_set),
		.tag_update_tag(tag_update_tag),
		.refill_error(refill_error)
	);

	perf_counters #(
		.COUNTER_WIDTH(COUNTER_WIDTH)
	) counters (
		.clk(clk),
		.reset(reset),
		.perf_hit(perf_hit),
		.perf_miss(perf_miss),
		.hit_count(hit_count),
		.miss_count(miss_count)
	);
endmodule

// File: testbench/axi_mem_model.sv
// AXI4-Lite read memory model
`timescale 1ns/1ps

module axi_mem_model
	import ifetch_pkg::*;
#(
	parameter int MEM_BYTES = 4096,
	parameter logic [31:0] SEED = 32'h772a_f61f
)
(
	input logic clk,
	input logic reset,

	// Test controls
	input logic random_delay,
	input logic force_error,

	// AXI4-Lite read slave
	input scalar_t araddr,
	input logic arvalid,
	output logic arready,
	output scalar_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);
	localparam int ADDR_BITS = $clog2(MEM_BYTES);

	logic [7:0] mem[MEM_BYTES];
	logic [31:0] fill_state;
	logic [31:0] delay_state;
	logic pending;
	scalar_t read_addr;
	logic [1:0] ar_wait;
	logic [1:0] r_wait;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Bus word, lowest address in bits 7:0
	function automatic scalar_t bus_word(input scalar_t addr);
		int base;
		base = int'(addr[ADDR_BITS-1:0]) & ~3;
		return {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]};
	endfunction

	// Random byte per location
	initial
	begin
		fill_state = SEED;
		for (int i = 0; i < MEM_BYTES; i++)
		begin
			fill_state = xorshift32(fill_state);
			mem[i] = fill_state[15:8];
		end
	end

	always @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			delay_state = SEED;
			arready <= 1'b0;
			rvalid <= 1'b0;
			rdata <= '0;
			rresp <= RESP_OKAY;
			pending <= 1'b0;
			read_addr <= '0;
			ar_wait <= '0;
			r_wait <= '0;
		end
		else
		begin
			// Address handshake, then pick the response delay
			if (arvalid && arready)
			begin
				arready <= 1'b0;
				pending <= 1'b1;
				read_addr <= araddr;
				delay_state = xorshift32(delay_state);
				r_wait <= random_delay ? delay_state[1:0] : 2'd0;
			end
			else if (arvalid && !pending)
			begin
				if (ar_wait == 0)
					arready <= 1'b1;
				else
					ar_wait <= ar_wait - 1'b1;
			end

			// Response after its delay
			if (pending && !rvalid)
			begin
				if (r_wait == 0)
				begin
					rvalid <= 1'b1;
					rdata <= bus_word(read_addr);
					rresp <= force_error ? RESP_SLVERR : RESP_OKAY;
				end
				else
					r_wait <= r_wait - 1'b1;
			end

			if (rvalid && rready)
			begin
				rvalid <= 1'b0;
				pending <= 1'b0;
				delay_state = xorshift32(delay_state);
				ar_wait <= random_delay ? delay_state[1:0] : 2'd0;
			end
		end
	end
endmodule

// File: testbench/ifetch_tb.sv
// Instruction fetch testbench
`timescale 1ns/1ps

module ifetch_tb
	import ifetch_pkg::*;
();
	localparam int COUNTER_WIDTH = 32;
	localparam logic [31:0] SEED = 32'h772a_f61f;
	localparam int READY_TIMEOUT = 100;
	localparam int RESULT_WINDOW = 3;
	localparam int REFILL_TIMEOUT = 200;
	localparam int MAX_ATTEMPTS = 4;

	typedef logic [COUNTER_WIDTH-1:0] count_t;
	typedef enum {FETCH_NONE, FETCH_HIT, FETCH_MISS} fetch_outcome_t;

	logic clk;
	logic reset;
	logic fetch_en;
	scalar_t fetch_pc;
	thread_idx_t fetch_thread;
	logic fetch_ready;
	logic inst_valid;
	scalar_t inst;
	scalar_t inst_pc;
	thread_idx_t inst_thread;
	logic rollback_en;
	thread_idx_t rollback_thread;
	logic miss_out;
	thread_idx_t miss_thread;
	scalar_t m_araddr;
	logic m_arvalid;
	logic m_arready;
	scalar_t m_rdata;
	logic [1:0] m_rresp;
	logic m_rvalid;
	logic m_rready;
	logic refill_error;
	count_t hit_count;
	count_t miss_count;
	logic random_delay;
	logic force_error;

	int checks;
	int errors;
	logic [31:0] rand_state;

	// Shadow cache, LRU bit names the next victim
	l1i_tag_t shadow_tag[L1I_WAYS][L1I_SETS];
	logic shadow_valid[L1I_WAYS][L1I_SETS];
	l1i_way_idx_t shadow_lru[L1I_SETS];
	int model_hits;
	int model_misses;

	ifetch_top #(
		.COUNTER_WIDTH(COUNTER_WIDTH),
		.DATA_SRAM_READ_NEW(1)
	) UUT (
		.clk(clk),
		.reset(reset),
		.fetch_en(fetch_en),
		.fetch_pc(fetch_pc),
		.fetch_thread(fetch_thread),
		.fetch_ready(fetch_ready),
		.inst_valid(inst_valid),
		.inst(inst),
		.inst_pc(inst_pc),
		.inst_thread(inst_thread),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.miss_out(miss_out),
		.miss_thread(miss_thread),
		.m_araddr(m_araddr),
		.m_arvalid(m_arvalid),
		.m_arready(m_arready),
		.m_rdata(m_rdata),
		.m_rresp(m_rresp),
		.m_rvalid(m_rvalid),
		.m_rready(m_rready),
		.refill_error(refill_error),
		.hit_count(hit_count),
		.miss_count(miss_count)
	);

	axi_mem_model #(
		.MEM_BYTES(4096),
		.SEED(SEED)
	) memory (
		.clk(clk),
		.reset(reset),
		.random_delay(random_delay),
		.force_error(force_error),
		.araddr(m_araddr),
		.arvalid(m_arvalid),
		.arready(m_arready),
		.rdata(m_rdata),
		.rresp(m_rresp),
		.rvalid(m_rvalid),
		.rready(m_rready)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Big-endian word, lowest byte on top
	function automatic scalar_t memory_word(input scalar_t pc);
		int base;
		base = int'(pc[11:0]) & ~3;
		return {memory.mem[base], memory.mem[base + 1], memory.mem[base + 2],
			memory.mem[base + 3]};
	endfunction

	// Returns 1 on a miss; the retry after the fill is a hit too
	function automatic int model_access(input scalar_t pc);
		l1i_addr_t addr;
		int way;
		addr = pc;
		for (way = 0; way < L1I_WAYS; way++)
		begin
			if (shadow_valid[way][addr.set_idx] && shadow_tag[way][addr.set_idx] == addr.tag)
			begin
				shadow_lru[addr.set_idx] = ~l1i_way_idx_t'(way);
				model_hits++;
				return 0;
			end
		end
		way = int'(shadow_lru[addr.set_idx]);
		shadow_valid[way][addr.set_idx] = 1'b1;
		shadow_tag[way][addr.set_idx] = addr.tag;
		shadow_lru[addr.set_idx] = ~l1i_way_idx_t'(way);
		model_misses++;
		model_hits++;
		return 1;
	endfunction

	task automatic compare_scalar(input scalar_t got, input scalar_t expected, input string what);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("ERROR at %0t: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic compare_thread(input thread_idx_t got, input thread_idx_t expected,
		input string what);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic compare_count(input count_t got, input count_t expected, input string what);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic compare_flag(input logic got, input logic expected, input string what);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("ERROR at %0t: %s is %b, expected %b", $time, what, got, expected);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before)
			$display("%-24s done, no errors", name);
		else
			$display("%-24s done, %0d errors", name, errors - errors_before);
	endtask

	// Reset DUT and shadow state, leave at a drive point
	task automatic reset_dut();
		reset = 1'b1;
		for (int way = 0; way < L1I_WAYS; way++)
		begin
			for (int set = 0; set < L1I_SETS; set++)
			begin
				shadow_valid[way][set] = 1'b0;
				shadow_tag[way][set] = '0;
			end
		end
		for (int set = 0; set < L1I_SETS; set++)
			shadow_lru[set] = '0;
		model_hits = 0;
		model_misses = 0;
		repeat (5) @(posedge clk);
		#0.5;
		reset = 1'b0;
	endtask

	// One request; the result window follows the pipeline depth
	task automatic issue_fetch(
		input scalar_t pc,
		input thread_idx_t thread,
		input logic kill,
		input thread_idx_t kill_thread,
		output fetch_outcome_t outcome,
		output scalar_t got_inst,
		output scalar_t got_pc,
		output thread_idx_t got_thread
	);
		int waited;
		outcome = FETCH_NONE;
		got_inst = '0;
		got_pc = '0;
		got_thread = '0;
		waited = 0;
		while (!fetch_ready && waited < READY_TIMEOUT)
		begin
			@(posedge clk);
			#0.5;
			waited++;
		end
		if (!fetch_ready)
		begin
			$display("Timed out at %0t waiting for fetch_ready before a fetch", $time);
			errors++;
			return;
		end
		fetch_en = 1'b1;
		fetch_pc = pc;
		fetch_thread = thread;
		@(posedge clk);
		#0.5;
		// Kill is live in the compare cycle only
		fetch_en = 1'b0;
		rollback_en = kill;
		rollback_thread = kill_thread;
		waited = 0;
		while (outcome == FETCH_NONE && waited < RESULT_WINDOW)
		begin
			if (miss_out)
			begin
				outcome = FETCH_MISS;
				compare_thread(miss_thread, thread, "miss_thread");
			end
			else if (inst_valid)
			begin
				outcome = FETCH_HIT;
				got_inst = inst;
				got_pc = inst_pc;
				got_thread = inst_thread;
			end
			else
			begin
				@(posedge clk);
				#0.5;
				rollback_en = 1'b0;
				waited++;
			end
		end
		rollback_en = 1'b0;
	endtask

	// Follow one refill, checking its reads and its tail
	task automatic wait_refill(input scalar_t pc);
		int waited;
		int beats;
		int ar_count;
		int tail;
		scalar_t line_base;
		line_base = {pc[31:4], 4'b0000};
		waited = 0;
		while (fetch_ready && waited < READY_TIMEOUT)
		begin
			@(posedge clk);
			#0.5;
			waited++;
		end
		if (fetch_ready)
		begin
			$display("Refill did not start after the miss at %0t", $time);
			errors++;
			return;
		end
		beats = 0;
		ar_count = 0;
		tail = 0;
		waited = 0;
		while (!fetch_ready && waited < REFILL_TIMEOUT)
		begin
			if (m_arvalid && m_arready)
			begin
				compare_scalar(m_araddr, line_base + scalar_t'(4 * ar_count), "refill address");
				ar_count++;
			end
			if (m_rvalid && m_rready)
				beats++;
			else if (beats == CACHE_LINE_WORDS)
				tail++;
			@(posedge clk);
			#0.5;
			waited++;
		end
		if (!fetch_ready)
		begin
			$display("Refill never finished, fetch_ready still low at %0t", $time);
			errors++;
			return;
		end
		compare_count(count_t'(beats), count_t'(CACHE_LINE_WORDS), "read beats in refill");
		// Data write, then tag write
		compare_count(count_t'(tail), count_t'(2), "cycles after last beat");
	endtask

	task automatic fetch_until_hit(
		input scalar_t pc,
		input thread_idx_t thread,
		output int misses,
		output scalar_t got_inst,
		output scalar_t got_pc,
		output thread_idx_t got_thread
	);
		fetch_outcome_t outcome;
		int attempts;
		misses = 0;
		attempts = 0;
		outcome = FETCH_NONE;
		while (outcome != FETCH_HIT && attempts < MAX_ATTEMPTS)
		begin
			issue_fetch(pc, thread, 1'b0, '0, outcome, got_inst, got_pc, got_thread);
			attempts++;
			if (outcome == FETCH_MISS)
			begin
				misses++;
				wait_refill(pc);
			end
		end
		if (outcome != FETCH_HIT)
		begin
			$display("Fetch of %h gave no instruction after %0d tries", pc, attempts);
			errors++;
		end
	endtask

	task automatic checked_fetch(input scalar_t pc, input thread_idx_t thread);
		int misses;
		int expected_misses;
		scalar_t got_inst;
		scalar_t got_pc;
		thread_idx_t got_thread;
		fetch_until_hit(pc, thread, misses, got_inst, got_pc, got_thread);
		expected_misses = model_access(pc);
		compare_count(count_t'(misses), count_t'(expected_misses),
			$sformatf("misses for %h", pc));
		compare_scalar(got_inst, memory_word(pc), $sformatf("inst at %h", pc));
		compare_scalar(got_pc, pc, "inst_pc");
		compare_thread(got_thread, thread, "inst_thread");
	endtask

	task automatic check_counters();
		compare_count(hit_count, count_t'(model_hits), "hit_count");
		compare_count(miss_count, count_t'(model_misses), "miss_count");
	endtask

	task automatic test_cold_fetch();
		int errors_before;
		errors_before = errors;
		reset_dut();
		checked_fetch(32'h0000_0044, 2'd1);
		compare_count(miss_count, count_t'(1), "miss_count after cold fetch");
		compare_count(hit_count, count_t'(1), "hit_count after cold fetch");
		report_test("Cold fetch", errors_before);
	endtask

	task automatic test_line_words();
		int errors_before;
		errors_before = errors;
		reset_dut();
		checked_fetch(32'h0000_01a8, 2'd0);
		for (int word = 0; word < CACHE_LINE_WORDS; word++)
			checked_fetch(32'h0000_01a0 + scalar_t'(4 * word), thread_idx_t'(word));
		check_counters();
		report_test("Whole line hits", errors_before);
	endtask

	// Three lines in set 3
	task automatic test_lru();
		int errors_before;
		scalar_t order[6];
		errors_before = errors;
		order = '{32'h030, 32'h130, 32'h030, 32'h230, 32'h130, 32'h030};
		reset_dut();
		foreach (order[i])
		begin
			checked_fetch(order[i], 2'd0);
			check_counters();
		end
		report_test("LRU replacement", errors_before);
	endtask

	task automatic test_rollback();
		int errors_before;
		fetch_outcome_t outcome;
		scalar_t got_inst;
		scalar_t got_pc;
		thread_idx_t got_thread;
		errors_before = errors;
		reset_dut();
		checked_fetch(32'h0000_0080, 2'd2);
		// Killed hit still counts as a hit
		issue_fetch(32'h0000_0084, 2'd2, 1'b1, 2'd2, outcome, got_inst, got_pc, got_thread);
		void'(model_access(32'h0000_0084));
		compare_flag(outcome == FETCH_NONE, 1'b1, "no result for rolled-back fetch");
		// Other thread is unaffected
		issue_fetch(32'h0000_0088, 2'd1, 1'b1, 2'd2, outcome, got_inst, got_pc, got_thread);
		void'(model_access(32'h0000_0088));
		compare_flag(outcome == FETCH_HIT, 1'b1, "hit for other thread");
		compare_scalar(got_inst, memory_word(32'h0000_0088), "inst for other thread");
		compare_scalar(got_pc, 32'h0000_0088, "inst_pc for other thread");
		compare_thread(got_thread, 2'd1, "inst_thread for other thread");
		check_counters();
		report_test("Rollback", errors_before);
	endtask

	task automatic test_slow_memory();
		int errors_before;
		errors_before = errors;
		reset_dut();
		random_delay = 1'b1;
		checked_fetch(32'h0000_02c4, 2'd3);
		checked_fetch(32'h0000_02cc, 2'd3);
		compare_flag(refill_error, 1'b0, "refill_error after OKAY refill");
		force_error = 1'b1;
		checked_fetch(32'h0000_03d0, 2'd0);
		force_error = 1'b0;
		compare_flag(refill_error, 1'b1, "refill_error after SLVERR refill");
		checked_fetch(32'h0000_03dc, 2'd0);
		check_counters();
		report_test("Slow memory", errors_before);
	endtask

	// 64 lines, any word, any thread
	task automatic test_random();
		int errors_before;
		scalar_t pc;
		errors_before = errors;
		reset_dut();
		random_delay = 1'b1;
		rand_state = SEED;
		for (int i = 0; i < 200; i++)
		begin
			rand_state = xorshift32(rand_state);
			pc = {22'd0, rand_state[5:0], rand_state[9:8], 2'b00};
			checked_fetch(pc, thread_idx_t'(rand_state[17:16]));
		end
		check_counters();
		report_test("Random sequence", errors_before);
	endtask

	initial
	begin
		reset = 1'b1;
		fetch_en = 1'b0;
		fetch_pc = '0;
		fetch_thread = '0;
		rollback_en = 1'b0;
		rollback_thread = '0;
		random_delay = 1'b0;
		force_error = 1'b0;
		checks = 0;
		errors = 0;
		test_cold_fetch();
		test_line_words();
		test_lru();
		test_rollback();
		test_slow_memory();
		test_random();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end
endmodule

// File: src.f
verilog/ifetch_pkg.sv
verilog/sram_1r1w.sv
verilog/ifetch_tag_stage.sv
verilog/ifetch_data_stage.sv
verilog/l2_refill_fsm.sv
verilog/perf_counters.sv
verilog/ifetch_top.sv
testbench/axi_mem_model.sv
testbench/ifetch_tb.sv
